//--- apb_readout.sv
//##########################################################
// APB slave with control and length registers, frame flag
// and count, and the frame buffer read mux.
//##########################################################

`timescale 1ns/1ps

`include "corr_config.svh"

module apb_readout (
	input  logic                          pllclk,
	input  logic                          reset,
	input  corr_pkg::apb_req_t            apb,
	output logic [31:0]                   prdata,
	input  corr_pkg::corr_frame_t         frame,
	input  logic                          frame_pulse,
	output logic                          enable,
	output logic [`CORR_INTEG_WIDTH-1:0]  integ_len,
	output logic                          frame_ready
);

	corr_pkg::apb_addr_u addr;
	corr_pkg::cplx_acc_t sel_cplx;
	corr_pkg::acc_t sel_acc;
	logic frame_hit;
	logic wr_en;
	logic clear_flag;
	logic [7:0] frame_cnt;

	assign addr = apb.paddr;
	assign wr_en = apb.psel && apb.penable && apb.pwrite;  // access phase only.
	assign clear_flag = wr_en && addr.regs.is_reg &&
		addr.regs.index == corr_pkg::REG_STATUS && apb.pwdata[0];

	assign frame_hit = !addr.frm.spare &&
		addr.frm.baseline < 3'(`CORR_NUM_BASELINES) &&
		addr.frm.lag < 2'(`CORR_NUM_LAGS);
	assign sel_cplx = frame[addr.frm.baseline][addr.frm.lag];
	assign sel_acc = addr.frm.part ? sel_cplx.im : sel_cplx.re;

	always_comb begin
		prdata = '0;
		if (!addr.regs.is_reg) begin
			if (frame_hit) begin
				prdata = 32'(sel_acc);  // sign extended.
			end
		end else begin
			case (addr.regs.index)
				corr_pkg::REG_CTRL:   prdata = {31'd0, enable};
				corr_pkg::REG_LEN:    prdata = 32'(integ_len);
				corr_pkg::REG_STATUS: prdata = {16'd0, frame_cnt, 7'd0, frame_ready};
				default:              prdata = '0;
			endcase
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			enable <= 1'b0;
			integ_len <= `CORR_INTEG_WIDTH'(1);
			frame_ready <= 1'b0;
			frame_cnt <= '0;
		end else begin
			if (wr_en && addr.regs.is_reg) begin
				case (addr.regs.index)
					corr_pkg::REG_CTRL: enable <= apb.pwdata[0];
					corr_pkg::REG_LEN:  integ_len <= apb.pwdata[`CORR_INTEG_WIDTH-1:0];
					default: ;
				endcase
			end
			if (frame_pulse) begin
				frame_ready <= 1'b1;  // set beats a clear in the same cycle.
				frame_cnt <= frame_cnt + 1'b1;
			end else if (clear_flag) begin
				frame_ready <= 1'b0;
			end
		end
	end

endmodule

//--- clock_gen.sv
//##########################################################
// testbench clock source, 40 ns period.
//##########################################################

`timescale 1ns/1ps

module clock_gen (
	output logic pllclk
);

	initial pllclk = 1'b0;

	always #20 pllclk = ~pllclk;

endmodule

//--- corr_config.svh
//##########################################################
// correlator sizing macros: lines, baselines, lags,
// history depth, accumulator and integration widths.
//##########################################################

`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// four 1-bit input lines.
`define CORR_NUM_LINES 4

// unordered pairs of the four lines.
`define CORR_NUM_BASELINES 6

// lags -1, 0 and +1.
`define CORR_NUM_LAGS 3

`define CORR_DEPTH 4

// kept narrow so that saturation is reachable in a short run.
`define CORR_ACC_WIDTH 10
`define CORR_INTEG_WIDTH 16

`endif

//--- corr_pkg.sv
//##########################################################
// correlator types: samples, history, accumulators, frame,
// APB request bundle and APB word address decode.
//##########################################################

`include "corr_config.svh"

package corr_pkg;

	typedef logic [`CORR_NUM_LINES-1:0] sample_word_t;

	// [line][tap], tap 0 holds the newest sample.
	typedef logic [`CORR_NUM_LINES-1:0][`CORR_DEPTH-1:0] line_history_t;

	typedef logic signed [`CORR_ACC_WIDTH-1:0] acc_t;

	typedef struct packed {
		acc_t re;
		acc_t im;
	} cplx_acc_t;

	// baseline 0 lag 0 real sits at the top of the word.
	typedef cplx_acc_t [0:`CORR_NUM_BASELINES-1][0:`CORR_NUM_LAGS-1] corr_frame_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic       is_reg;   // clear for a frame read.
		logic       spare;    // must be zero.
		logic [2:0] baseline;
		logic [1:0] lag;      // 0 is lag -1.
		logic       part;     // 0 real, 1 quadrature.
	} frame_addr_t;

	typedef struct packed {
		logic       is_reg;
		logic [6:0] index;
	} reg_addr_t;

	typedef union packed {
		frame_addr_t frm;
		reg_addr_t   regs;
	} apb_addr_u;

	typedef enum logic [6:0] {
		REG_CTRL   = 7'd0,
		REG_LEN    = 7'd1,
		REG_STATUS = 7'd2
	} reg_index_e;

endpackage

//--- correlator_accum.sv
//##########################################################
// baseline and lag sign products, saturating accumulators,
// integration counter and frame snapshot.
//##########################################################

`timescale 1ns/1ps

`include "corr_config.svh"

module correlator_accum (
	input  logic                          pllclk,
	input  logic                          reset,
	input  corr_pkg::line_history_t       history,
	input  logic                          hist_valid,
	input  logic                          enable,
	input  logic [`CORR_INTEG_WIDTH-1:0]  integ_len,
	output corr_pkg::corr_frame_t         frame,
	output logic                          frame_pulse
);

	localparam corr_pkg::acc_t ACC_MAX = corr_pkg::acc_t'((1 << (`CORR_ACC_WIDTH - 1)) - 1);
	localparam corr_pkg::acc_t ACC_MIN = -ACC_MAX;
	localparam corr_pkg::acc_t ONE = corr_pkg::acc_t'(1);

	// an accumulator parked at either rail stays there.
	function automatic corr_pkg::acc_t sat_step(input corr_pkg::acc_t acc, input logic agree);
		if (acc == ACC_MAX || acc == ACC_MIN) begin
			sat_step = acc;
		end else if (agree) begin
			sat_step = acc + ONE;
		end else begin
			sat_step = acc - ONE;
		end
	endfunction

	corr_pkg::corr_frame_t acc;
	wire corr_pkg::corr_frame_t acc_next;
	logic [`CORR_INTEG_WIDTH-1:0] cnt;
	logic step;
	logic last;

	for (genvar a = 0; a < `CORR_NUM_LINES - 1; a++) begin : g_a
		for (genvar b = a + 1; b < `CORR_NUM_LINES; b++) begin : g_b
			// pairs enumerate as 0-1, 0-2, 0-3, 1-2, 1-3, 2-3.
			localparam int BL = a * (2 * `CORR_NUM_LINES - a - 1) / 2 + (b - a - 1);
			for (genvar li = 0; li < `CORR_NUM_LAGS; li++) begin : g_lag
				assign acc_next[BL][li].re = sat_step(acc[BL][li].re,
					history[a][1] == history[b][li]);
				assign acc_next[BL][li].im = sat_step(acc[BL][li].im,
					history[a][1] == history[b][li + 1]);
			end
		end
	end

	assign step = hist_valid && enable;
	assign last = (cnt == integ_len - 1'b1);  // this sample closes the integration.
	assign frame_pulse = step && last;

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			acc <= '0;
			cnt <= '0;
			frame <= '0;
		end else if (step) begin
			if (last) begin
				frame <= acc_next;  // includes the closing sample.
				acc <= '0;
				cnt <= '0;
			end else begin
				acc <= acc_next;
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

//--- correlator_asserts.sv
//##########################################################
// concurrent checks on the correlator top, bound from here.
//##########################################################

`timescale 1ns/1ps

module correlator_asserts (
	input logic pllclk,
	input logic reset,
	input logic smp_strobe,
	input logic hist_valid,
	input logic frame_pulse,
	input logic frame_ready
);

	pulse_one_cycle: assert property (@(posedge pllclk) disable iff (!reset)
		frame_pulse |=> !frame_pulse)
		else $error("frame_pulse stayed high for more than one cycle");

	ready_low_in_reset: assert property (@(posedge pllclk) !reset |=> !frame_ready)
		else $error("frame_ready was not cleared by reset");

	valid_after_strobe: assert property (@(posedge pllclk) disable iff (!reset)
		smp_strobe |=> hist_valid)
		else $error("hist_valid did not follow smp_strobe");

	no_valid_without_strobe: assert property (@(posedge pllclk) disable iff (!reset)
		!smp_strobe |=> !hist_valid)
		else $error("hist_valid rose without a preceding smp_strobe");

endmodule

bind correlator_top correlator_asserts asserts_i (
	.pllclk      (pllclk),
	.reset       (reset),
	.smp_strobe  (smp_strobe),
	.hist_valid  (hist_valid),
	.frame_pulse (frame_pulse),
	.frame_ready (frame_ready)
);

//--- correlator_tb.sv
//##########################################################
// correlator testbench with stimulus table, reference model,
// APB read and write tasks, checks and watchdog.
//##########################################################

`timescale 1ns/1ps

`include "corr_config.svh"

module correlator_tb;

	localparam int ACC_MAX = (1 << (`CORR_ACC_WIDTH - 1)) - 1;
	localparam int NUM_ROWS = 6;
	localparam int FRAME_WAIT = 20;

	typedef struct packed {
		logic [15:0] len;
		logic [1:0]  pattern;         // 0 random, 1 all ones, 2 alternating lines.
		logic [3:0]  gap;
		logic        disabled_first;  // strobes with enable low before the frame.
		logic [1:0]  rail;            // 1 all at +max, 2 some at -max.
	} row_t;

	localparam row_t ROWS [NUM_ROWS] = '{
		'{16'd20, 2'd0, 4'd1, 1'b0, 2'd0},
		'{16'd20, 2'd0, 4'd3, 1'b0, 2'd0},
		'{16'd600, 2'd1, 4'd1, 1'b0, 2'd1},
		'{16'd600, 2'd2, 4'd1, 1'b0, 2'd2},
		'{16'd20, 2'd0, 4'd2, 1'b1, 2'd0},
		'{16'd37, 2'd0, 4'd1, 1'b0, 2'd0}
	};

	logic pllclk;
	logic reset;
	logic smp_strobe;
	logic [31:0] prdata;
	logic frame_ready;
	corr_pkg::sample_word_t samples;
	corr_pkg::apb_req_t apb;

	logic [3:0] model_hist [`CORR_NUM_LINES];  // bit t is tap t.
	int model_acc [`CORR_NUM_BASELINES][`CORR_NUM_LAGS][2];
	int expect_frame [`CORR_NUM_BASELINES][`CORR_NUM_LAGS][2];
	int model_cnt;
	int model_frames;
	int cur_len;
	logic model_enable;

	clock_gen clk_i (
		.pllclk (pllclk)
	);

	correlator_top dut_i (
		.pllclk      (pllclk),
		.reset       (reset),
		.samples     (samples),
		.smp_strobe  (smp_strobe),
		.apb         (apb),
		.prdata      (prdata),
		.frame_ready (frame_ready)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else
			report_failure($sformatf("FAIL at %0t ns: %s expected %0d, got %0d", $time, name,
				$signed(expected), $signed(actual)));
	endtask

	function automatic int add_clipped(input int acc, input bit agree);
		if (acc == ACC_MAX || acc == -ACC_MAX) begin
			add_clipped = acc;
		end else begin
			add_clipped = agree ? acc + 1 : acc - 1;
		end
	endfunction

	function automatic logic [3:0] next_word(input logic [1:0] pattern);
		case (pattern)
			2'd1: next_word = 4'hf;
			2'd2: next_word = 4'b0101;  // neighbouring lines disagree.
			default: next_word = 4'($urandom());
		endcase
	endfunction

	// lag index lg stands for lag lg-1, so real uses tap lg and quadrature tap lg+1.
	task automatic model_sample(input logic [3:0] word);
		int bl;
		for (int ln = 0; ln < `CORR_NUM_LINES; ln++) begin
			model_hist[ln] = {model_hist[ln][2:0], word[ln]};
		end
		if (model_enable) begin
			bl = 0;
			for (int a = 0; a < `CORR_NUM_LINES - 1; a++) begin
				for (int b = a + 1; b < `CORR_NUM_LINES; b++) begin
					for (int lg = 0; lg < `CORR_NUM_LAGS; lg++) begin
						model_acc[bl][lg][0] = add_clipped(model_acc[bl][lg][0],
							model_hist[a][1] == model_hist[b][lg]);
						model_acc[bl][lg][1] = add_clipped(model_acc[bl][lg][1],
							model_hist[a][1] == model_hist[b][lg + 1]);
					end
					bl++;
				end
			end
			model_cnt++;
			if (model_cnt == cur_len) begin
				expect_frame = model_acc;
				model_acc = '{default: 0};
				model_cnt = 0;
				model_frames++;
			end
		end
	endtask

	task automatic drive_sample(input logic [3:0] word, input int gap);
		samples = word;
		smp_strobe = 1'b1;
		model_sample(word);
		@(posedge pllclk);
		#1;
		smp_strobe = 1'b0;
		repeat (gap - 1) begin
			@(posedge pllclk);
			#1;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge pllclk);
		#1;
		apb.penable = 1'b1;
		@(posedge pllclk);
		#1;
		apb = '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
		@(posedge pllclk);
		#1;
		apb.penable = 1'b1;
		@(negedge pllclk);
		data = prdata;  // mid access phase.
		@(posedge pllclk);
		#1;
		apb = '0;
	endtask

	task automatic expect_read(input logic [7:0] addr, input logic [31:0] expected,
		input string name);
		logic [31:0] rd;
		apb_read(addr, rd);
		check_value(name, expected, rd);
	endtask

	task automatic wait_frame();
		int waited;
		waited = 0;
		while (!frame_ready && waited < FRAME_WAIT) begin
			@(posedge pllclk);
			#1;
			waited++;
		end
		assert (frame_ready) else
			report_failure("frame_ready never rose after the last sample of the integration");
	endtask

	task automatic run_row(input row_t row);
		int len;
		int low_hits;
		string name;
		logic [31:0] rd;
		len = int'(row.len);
		cur_len = len;
		low_hits = 0;
		apb_write(8'h81, 32'(row.len));
		if (row.disabled_first) begin
			apb_write(8'h80, 32'd0);
			model_enable = 1'b0;
			for (int i = 0; i < 2 * len; i++) begin
				drive_sample(next_word(row.pattern), int'(row.gap));
				assert (!frame_ready) else
					report_failure("frame_ready rose while the correlator was disabled");
			end
		end
		apb_write(8'h80, 32'd1);
		model_enable = 1'b1;
		for (int i = 0; i < len; i++) begin
			drive_sample(next_word(row.pattern), int'(row.gap));
		end
		wait_frame();
		for (int bl = 0; bl < `CORR_NUM_BASELINES; bl++) begin
			for (int lg = 0; lg < `CORR_NUM_LAGS; lg++) begin
				for (int pt = 0; pt < 2; pt++) begin
					name = $sformatf("prdata frame[%0d][%0d].%s", bl, lg, pt ? "im" : "re");
					apb_read({2'b00, 3'(bl), 2'(lg), 1'(pt)}, rd);
					check_value(name, 32'(expect_frame[bl][lg][pt]), rd);
					if (row.rail == 2'd1) begin
						check_value(name, 32'(ACC_MAX), rd);
					end
					if ($signed(rd) == -ACC_MAX) begin
						low_hits++;
					end
				end
			end
		end
		if (row.rail == 2'd2) begin
			assert (low_hits > 0) else
				report_failure("no accumulator reached the negative rail");
		end
		expect_read(8'h82, {16'd0, 8'(model_frames), 7'd0, 1'b1}, "prdata status");
		apb_write(8'h82, 32'd1);
		expect_read(8'h82, {16'd0, 8'(model_frames), 8'd0}, "prdata status after clear");
	endtask

	initial begin
		void'($urandom(66));
		reset = 1'b0;
		smp_strobe = 1'b0;
		samples = '0;
		apb = '0;
		model_acc = '{default: 0};
		expect_frame = '{default: 0};
		model_cnt = 0;
		model_frames = 0;
		cur_len = 1;
		model_enable = 1'b0;
		for (int ln = 0; ln < `CORR_NUM_LINES; ln++) begin
			model_hist[ln] = 4'd0;
		end
		repeat (8) @(posedge pllclk);
		#1;
		reset = 1'b1;
		expect_read(8'h82, 32'd0, "prdata status after reset");
		expect_read(8'h80, 32'd0, "prdata control after reset");
		expect_read(8'h81, 32'd1, "prdata integ_len after reset");
		expect_read(8'h83, 32'd0, "prdata unmapped reg 3");
		expect_read(8'hff, 32'd0, "prdata unmapped reg 127");
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(ROWS[r]);
		end
		$display("Test completed successfully");
		$finish;
	end

	initial begin : watchdog
		int budget;
		budget = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			budget += int'(ROWS[r].len) * int'(ROWS[r].gap) + 200;
		end
		#(budget * 40);
		report_failure("watchdog expired before the stimulus table was finished");
	end

endmodule

//--- correlator_top.sv
//##########################################################
// correlator top: history lines, accumulators, APB side.
//##########################################################

`timescale 1ns/1ps

`include "corr_config.svh"

module correlator_top (
	input  logic                   pllclk,
	input  logic                   reset,
	input  corr_pkg::sample_word_t samples,
	input  logic                   smp_strobe,
	input  corr_pkg::apb_req_t     apb,
	output logic [31:0]            prdata,
	output logic                   frame_ready
);

	corr_pkg::line_history_t history;
	corr_pkg::corr_frame_t frame;
	logic hist_valid;
	logic enable;
	logic frame_pulse;
	logic [`CORR_INTEG_WIDTH-1:0] integ_len;

	sample_delay_lines lines_i (
		.pllclk     (pllclk),
		.reset      (reset),
		.samples    (samples),
		.smp_strobe (smp_strobe),
		.history    (history),
		.hist_valid (hist_valid)
	);

	correlator_accum accum_i (
		.pllclk      (pllclk),
		.reset       (reset),
		.history     (history),
		.hist_valid  (hist_valid),
		.enable      (enable),
		.integ_len   (integ_len),
		.frame       (frame),
		.frame_pulse (frame_pulse)
	);

	apb_readout apb_i (
		.pllclk      (pllclk),
		.reset       (reset),
		.apb         (apb),
		.prdata      (prdata),
		.frame       (frame),
		.frame_pulse (frame_pulse),
		.enable      (enable),
		.integ_len   (integ_len),
		.frame_ready (frame_ready)
	);

endmodule

//--- flist.f
+incdir+.
corr_pkg.sv
sample_delay_lines.sv
correlator_accum.sv
apb_readout.sv
correlator_top.sv
clock_gen.sv
correlator_asserts.sv
correlator_tb.sv

//--- run.sh
#!/bin/sh
# build and run the correlator testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f flist.f \
	--top-module correlator_tb \
	-o correlator_sim

./obj_dir/correlator_sim

//--- sample_delay_lines.sv
//##########################################################
// per-line sample history and the delayed sample strobe.
//##########################################################

`timescale 1ns/1ps

`include "corr_config.svh"

module sample_delay_lines (
	input  logic                    pllclk,
	input  logic                    reset,
	input  corr_pkg::sample_word_t  samples,
	input  logic                    smp_strobe,
	output corr_pkg::line_history_t history,
	output logic                    hist_valid
);

	corr_pkg::line_history_t hist_next;

	// new sample enters at tap 0, the oldest falls off the end.
	always_comb begin
		for (int ln = 0; ln < `CORR_NUM_LINES; ln++) begin
			hist_next[ln] = {history[ln][`CORR_DEPTH-2:0], samples[ln]};
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			history <= '0;
			hist_valid <= 1'b0;
		end else begin
			hist_valid <= smp_strobe;  // lines up with the shifted history.
			if (smp_strobe) begin
				history <= hist_next;
			end
		end
	end

endmodule
